/* common/capture_pkg.sv */
package capture_pkg;

    // ======================================
    // Stream sideband
    // ======================================
    typedef logic [7:0]  tid_t;
    typedef logic [11:0] tdest_t;
    typedef logic [31:0] tuser_t;

    // Sideband as recorded for one packet, tid in the top bits
    typedef struct packed {
        tid_t   tid;
        tdest_t tdest;
        tuser_t tuser;
    } meta_t;

    localparam int meta_width = $bits(meta_t);

    // ======================================
    // Register side
    // ======================================
    typedef logic [15:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [15:0] byte_len_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t resp_okay = 2'b00;

    // Register map
    localparam axil_addr_t reg_control     = 16'h0000;
    localparam axil_addr_t reg_status      = 16'h0004;
    localparam axil_addr_t reg_pkt_len     = 16'h0008;
    localparam axil_addr_t reg_mem_size    = 16'h000C;
    localparam axil_addr_t reg_meta_width  = 16'h0010;
    localparam axil_addr_t reg_meta_lo     = 16'h0014;
    localparam axil_addr_t reg_meta_hi     = 16'h0018;

    // Packet memory is visible from here upwards
    localparam axil_addr_t mem_window_base = 16'h8000;

endpackage

/* common/pkt_mem_rd_if.sv */
`timescale 1ns/1ps

interface pkt_mem_rd_if #(
    parameter int DATA_BYTE_WID   = 8,
    parameter int PACKET_MEM_SIZE = 2048
);
    import capture_pkg::*;

    localparam int mem_depth = PACKET_MEM_SIZE / DATA_BYTE_WID;
    localparam int addr_wid  = $clog2(mem_depth);

    // Memory read port, data one cycle after the address
    logic [addr_wid-1:0]        rd_addr;
    logic [DATA_BYTE_WID*8-1:0] rd_data;

    // Capture status and control
    byte_len_t pkt_len;
    logic      done;
    logic      armed;
    logic      overflow;
    logic      arm;

    modport data_writer (input rd_addr, arm, output rd_data, pkt_len, done, armed, overflow);
    modport regs (output rd_addr, arm, input rd_data, pkt_len, done, armed, overflow);

endinterface

/* packet_capture/capture_data_writer.sv */
`timescale 1ns/1ps

module capture_data_writer #(
    parameter int DATA_BYTE_WID   = 8,
    parameter int PACKET_MEM_SIZE = 2048
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       tvalid,
    output logic                       tready,
    input  logic [DATA_BYTE_WID*8-1:0] tdata,
    input  logic [DATA_BYTE_WID-1:0]   tkeep,
    input  logic                       tlast,
    output logic                       beat_accept,
    output logic                       first_beat,
    pkt_mem_rd_if.data_writer          mem_if
);
    import capture_pkg::*;

    localparam int mem_depth = PACKET_MEM_SIZE / DATA_BYTE_WID;
    localparam int addr_wid  = $clog2(mem_depth);

    typedef enum logic [1:0] {st_idle, st_capturing, st_done} state_t;

    state_t                     state;
    logic [DATA_BYTE_WID*8-1:0] mem [mem_depth];
    logic [addr_wid:0]          wr_ptr;
    logic                       mem_full;
    byte_len_t                  byte_cnt;
    logic                       overflow;

    // Leading valid bytes of a beat, a gap in tkeep ends the count
    function automatic byte_len_t keep_count(input logic [DATA_BYTE_WID-1:0] keep);
        byte_len_t n;
        logic      run;
        n   = '0;
        run = 1'b1;
        for (int i = 0; i < DATA_BYTE_WID; i++) begin
            run = run & keep[i];
            if (run)
            begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    // Stream only stalls while not armed
    assign tready      = (state == st_capturing);
    assign beat_accept = tvalid && tready;
    assign first_beat  = (state == st_capturing) && (wr_ptr == '0);
    assign mem_full    = (wr_ptr == (addr_wid+1)'(mem_depth));

    // ======================================
    // Capture control
    // ======================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= st_idle;
            wr_ptr   <= '0;
            byte_cnt <= '0;
            overflow <= 1'b0;
        end
        else if (mem_if.arm)
        begin
            state    <= st_capturing;
            wr_ptr   <= '0;
            byte_cnt <= '0;
            overflow <= 1'b0;
        end
        else if (beat_accept)
        begin
            byte_cnt <= byte_cnt + keep_count(tkeep);
            // Beats past the end are counted but dropped
            if (mem_full)
            begin
                overflow <= 1'b1;
            end
            else
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (tlast)
            begin
                state <= st_done;
            end
        end
    end

    // ======================================
    // Packet memory
    // ======================================
    always_ff @(posedge clk)
    begin
        if (beat_accept && !mem_full)
        begin
            mem[wr_ptr[addr_wid-1:0]] <= tdata;
        end
        mem_if.rd_data <= mem[mem_if.rd_addr];
    end

    assign mem_if.pkt_len  = byte_cnt;
    assign mem_if.done     = (state == st_done);
    assign mem_if.armed    = (state == st_capturing);
    assign mem_if.overflow = overflow;

endmodule

/* packet_capture/capture_meta_latch.sv */
`timescale 1ns/1ps

module capture_meta_latch (
    input  logic                clk,
    input  logic                reset,
    input  logic                beat_accept,
    input  logic                first_beat,
    input  capture_pkg::tid_t   tid,
    input  capture_pkg::tdest_t tdest,
    input  capture_pkg::tuser_t tuser,
    output capture_pkg::meta_t  meta
);
    import capture_pkg::*;

    meta_t meta_in;
    logic  take;

    // Sideband as it stands on the current beat
    assign meta_in.tid   = tid;
    assign meta_in.tdest = tdest;
    assign meta_in.tuser = tuser;

    // Only the opening beat of a packet counts
    assign take = beat_accept && first_beat;

    // Later changes on the sideband within the same packet are ignored
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            meta <= '0;
        end
        else if (take)
        begin
            meta <= meta_in;
        end
    end

endmodule

/* packet_capture/capture_regs.sv */
`timescale 1ns/1ps

module capture_regs #(
    parameter int DATA_BYTE_WID   = 8,
    parameter int PACKET_MEM_SIZE = 2048
) (
    input  logic                    clk,
    input  logic                    reset,
    input  capture_pkg::meta_t      meta,
    pkt_mem_rd_if.regs              mem_if,
    input  logic                    awvalid,
    output logic                    awready,
    input  capture_pkg::axil_addr_t awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  capture_pkg::axil_data_t wdata,
    output logic                    bvalid,
    input  logic                    bready,
    output capture_pkg::resp_t      bresp,
    input  logic                    arvalid,
    output logic                    arready,
    input  capture_pkg::axil_addr_t araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output capture_pkg::axil_data_t rdata,
    output capture_pkg::resp_t      rresp
);
    import capture_pkg::*;

    localparam int byte_sel_wid = $clog2(DATA_BYTE_WID);
    localparam int word_wid     = $clog2(PACKET_MEM_SIZE / DATA_BYTE_WID);
    localparam int lanes        = DATA_BYTE_WID / 4;

    typedef enum logic [1:0] {wr_idle, wr_ack, wr_resp} wr_state_t;
    typedef enum logic [1:0] {rd_idle, rd_ack, rd_wait, rd_resp} rd_state_t;

    wr_state_t   wr_state;
    rd_state_t   rd_state;
    axil_addr_t  addr_q;
    axil_addr_t  win_offset;
    logic        in_window;
    int unsigned lane_idx;

    // ======================================
    // Write channel
    // ======================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_state <= wr_idle;
        end
        else
        begin
            case (wr_state)
                wr_idle: if (awvalid && wvalid) wr_state <= wr_ack;
                wr_ack:  wr_state <= wr_resp;
                wr_resp: if (bready) wr_state <= wr_idle;
                default: wr_state <= wr_idle;
            endcase
        end
    end

    assign awready = (wr_state == wr_ack);
    assign wready  = (wr_state == wr_ack);
    assign bvalid  = (wr_state == wr_resp);
    assign bresp   = resp_okay;

    // Arm strobe on the handshake cycle
    assign mem_if.arm = (wr_state == wr_ack) && (awaddr == reg_control) && wdata[0];

    // ======================================
    // Read channel
    // ======================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_state <= rd_idle;
        end
        else
        begin
            case (rd_state)
                rd_idle: if (arvalid) rd_state <= rd_ack;
                rd_ack:  rd_state <= rd_wait;
                rd_wait: rd_state <= rd_resp;
                rd_resp: if (rready) rd_state <= rd_idle;
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // Address held until the response is taken
    always_ff @(posedge clk)
    begin
        if (rd_state == rd_ack)
        begin
            addr_q <= araddr;
        end
    end

    assign arready = (rd_state == rd_ack);
    assign rvalid  = (rd_state == rd_resp);
    assign rresp   = resp_okay;

    // Memory window decode
    assign win_offset     = addr_q - mem_window_base;
    assign in_window      = (addr_q >= mem_window_base) && (int'(win_offset) < PACKET_MEM_SIZE);
    assign mem_if.rd_addr = win_offset[byte_sel_wid +: word_wid];
    assign lane_idx       = int'(win_offset[15:2]) % lanes;

    always_comb
    begin
        rdata = '0;
        if (in_window)
        begin
            rdata = mem_if.rd_data[lane_idx*32 +: 32];
        end
        else
        begin
            case (addr_q)
                reg_status:     rdata = axil_data_t'({mem_if.overflow, mem_if.armed, mem_if.done});
                reg_pkt_len:    rdata = axil_data_t'(mem_if.pkt_len);
                reg_mem_size:   rdata = axil_data_t'(PACKET_MEM_SIZE);
                reg_meta_width: rdata = axil_data_t'(meta_width);
                reg_meta_lo:    rdata = meta[31:0];
                reg_meta_hi:    rdata = axil_data_t'(meta[meta_width-1:32]);
                default:        rdata = '0;
            endcase
        end
    end

endmodule

/* src/axi4s_packet_capture.sv */
`timescale 1ns/1ps

module axi4s_packet_capture #(
    parameter int DATA_BYTE_WID   = 8,
    parameter int PACKET_MEM_SIZE = 2048
) (
    input  logic                       clk,
    input  logic                       reset,
    // Stream input
    input  logic                       tvalid,
    output logic                       tready,
    input  logic [DATA_BYTE_WID*8-1:0] tdata,
    input  logic [DATA_BYTE_WID-1:0]   tkeep,
    input  logic                       tlast,
    input  capture_pkg::tid_t          tid,
    input  capture_pkg::tdest_t        tdest,
    input  capture_pkg::tuser_t        tuser,
    // AXI4-Lite register port
    input  logic                       awvalid,
    output logic                       awready,
    input  capture_pkg::axil_addr_t    awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  capture_pkg::axil_data_t    wdata,
    output logic                       bvalid,
    input  logic                       bready,
    output capture_pkg::resp_t         bresp,
    input  logic                       arvalid,
    output logic                       arready,
    input  capture_pkg::axil_addr_t    araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output capture_pkg::axil_data_t    rdata,
    output capture_pkg::resp_t         rresp
);
    import capture_pkg::*;

    logic  beat_accept;
    logic  first_beat;
    meta_t meta;

    pkt_mem_rd_if #(
        .DATA_BYTE_WID   (DATA_BYTE_WID),
        .PACKET_MEM_SIZE (PACKET_MEM_SIZE)
    ) mem_if ();

    // ======================================
    // Capture path
    // ======================================
    capture_data_writer #(
        .DATA_BYTE_WID   (DATA_BYTE_WID),
        .PACKET_MEM_SIZE (PACKET_MEM_SIZE)
    ) writer0 (
        .clk, .reset, .tvalid, .tready, .tdata, .tkeep, .tlast,
        .beat_accept, .first_beat, .mem_if (mem_if.data_writer)
    );

    capture_meta_latch meta0 (
        .clk, .reset, .beat_accept, .first_beat, .tid, .tdest, .tuser, .meta
    );

    // Software view
    capture_regs #(
        .DATA_BYTE_WID   (DATA_BYTE_WID),
        .PACKET_MEM_SIZE (PACKET_MEM_SIZE)
    ) regs0 (
        .clk, .reset, .meta, .mem_if (mem_if.regs),
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp
    );

endmodule

/* verif/tb_packet_capture.sv */
`timescale 1ns/1ps

module tb_packet_capture;
    import capture_pkg::*;

    localparam int data_bytes = 8;
    localparam int mem_bytes  = 2048;
    localparam int wait_limit = 2000;
    localparam int poll_limit = 100;

    logic        clk;
    logic        reset;
    logic        tvalid;
    logic        tready;
    logic [63:0] tdata;
    logic [7:0]  tkeep;
    logic        tlast;
    tid_t        tid;
    tdest_t      tdest;
    tuser_t      tuser;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    axil_addr_t  awaddr, araddr;
    axil_data_t  wdata, rdata;
    resp_t       bresp, rresp;

    integer      seed;
    int          test_num;
    int          test_errors;
    int          total_errors;
    int          tests_bad;

    // Reference packet in stream byte order
    logic [7:0]  model_bytes[$];
    int          model_len;
    tid_t        model_tid;
    tdest_t      model_tdest;
    tuser_t      model_tuser;

    axi4s_packet_capture #(
        .DATA_BYTE_WID   (data_bytes),
        .PACKET_MEM_SIZE (mem_bytes)
    ) dut0 (.*);

    always #10 clk = ~clk;

    // ========================================
    // Check and report helpers
    // ========================================
    task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        test_errors++;
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (test_errors == 0)
        begin
            $display("test %0d %s: ok", test_num, name);
        end
        else
        begin
            $display("test %0d %s: FAILED with %0d errors", test_num, name, test_errors);
            tests_bad++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // ========================================
    // AXI4-Lite master on falling edges
    // ========================================
    task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
        int n;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!awready && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!awready)
        begin
            report_timeout("awready");
        end
        else
        begin
            // Address and data are taken in the same cycle
            check_equal("wready", 32'(wready), 32'h1);
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!bvalid)
        begin
            report_timeout("bvalid");
        end
        check_equal("bresp", 32'(bresp), 32'h0);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        data    = '0;
        n = 0;
        @(negedge clk);
        while (!arready && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!arready)
        begin
            report_timeout("arready");
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (!rvalid)
        begin
            report_timeout("rvalid");
        end
        else
        begin
            data = rdata;
            check_equal("rresp", 32'(rresp), 32'h0);
        end
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_done(output axil_data_t status);
        int n;
        n = 0;
        axil_read(reg_status, status);
        while (!status[0] && n < poll_limit)
        begin
            axil_read(reg_status, status);
            n++;
        end
        if (!status[0])
        begin
            report_timeout("done in the status register");
        end
    endtask

    // ========================================
    // Stream source with byte model
    // ========================================
    task automatic send_packet(input int len, input bit vary_side);
        logic [31:0] r;
        int          nbeats;
        int          b;
        int          i;
        int          n;
        model_bytes.delete();
        model_len   = len;
        r           = $random(seed);
        model_tid   = r[7:0];
        model_tdest = r[19:8];
        model_tuser = $random(seed);
        nbeats      = (len + data_bytes - 1) / data_bytes;
        for (b = 0; b < nbeats; b++)
        begin
            tkeep = '0;
            for (i = 0; i < data_bytes; i++)
            begin
                r = $random(seed);
                tdata[8*i +: 8] = r[7:0];
                if (b * data_bytes + i < len)
                begin
                    tkeep[i] = 1'b1;
                    model_bytes.push_back(r[7:0]);
                end
            end
            // Sideband of the first beat is what the capture must keep
            if (b == 0)
            begin
                tid   = model_tid;
                tdest = model_tdest;
                tuser = model_tuser;
            end
            else if (vary_side)
            begin
                r     = $random(seed);
                tid   = r[7:0];
                tdest = r[31:20];
                tuser = $random(seed);
            end
            tlast  = (b == nbeats - 1);
            tvalid = 1'b1;
            n = 0;
            while (!tready && n < wait_limit)
            begin
                @(negedge clk);
                n++;
            end
            if (!tready)
            begin
                report_timeout("tready");
                tvalid = 1'b0;
                tlast  = 1'b0;
                return;
            end
            @(negedge clk);
        end
        tvalid = 1'b0;
        tlast  = 1'b0;
    endtask

    task automatic check_readback(input int cmp_bytes);
        axil_data_t got;
        axil_data_t exp;
        axil_data_t mask;
        axil_addr_t a;
        int         k;
        int         j;
        axil_read(reg_pkt_len, got);
        check_equal("pkt_len", got, 32'(model_len));
        axil_read(reg_meta_lo, got);
        check_equal("meta_lo", got, model_tuser);
        axil_read(reg_meta_hi, got);
        check_equal("meta_hi", got, {12'h000, model_tid, model_tdest});
        for (k = 0; k < (cmp_bytes + 3) / 4; k++)
        begin
            exp  = '0;
            mask = '0;
            for (j = 0; j < 4; j++)
            begin
                if (4 * k + j < cmp_bytes)
                begin
                    exp[8*j +: 8]  = model_bytes[4 * k + j];
                    mask[8*j +: 8] = 8'hff;
                end
            end
            a = mem_window_base + axil_addr_t'(4 * k);
            axil_read(a, got);
            check_equal($sformatf("rdata at 0x%04h", a), got & mask, exp);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial
    begin
        axil_data_t rd;
        int         len;
        int         i;
        seed = 32'h3dbf_2036;
        test_num = 0;
        test_errors = 0;
        total_errors = 0;
        tests_bad = 0;
        clk = 1'b0;
        reset = 1'b1;
        tvalid = 1'b0;
        tdata = '0;
        tkeep = '0;
        tlast = 1'b0;
        tid = '0;
        tdest = '0;
        tuser = '0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        axil_read(reg_mem_size, rd);
        check_equal("mem_size", rd, 32'd2048);
        axil_read(reg_meta_width, rd);
        check_equal("meta_width", rd, 32'd52);
        axil_read(reg_status, rd);
        check_equal("status", rd, 32'h0);
        end_test("info registers");

        // Offer a beat without arming
        tdata  = 64'h0123_4567_89ab_cdef;
        tkeep  = 8'hff;
        tlast  = 1'b1;
        tvalid = 1'b1;
        for (i = 0; i < 20; i++)
        begin
            @(negedge clk);
            check_equal("tready", 32'(tready), 32'h0);
        end
        tvalid = 1'b0;
        tlast  = 1'b0;
        axil_read(reg_status, rd);
        check_equal("status", rd, 32'h0);
        axil_read(reg_pkt_len, rd);
        check_equal("pkt_len", rd, 32'h0);
        end_test("idle back-pressure");

        axil_write(reg_control, 32'h1);
        len = 64 + int'($unsigned($random(seed)) % 193);
        send_packet(len, 1'b0);
        wait_done(rd);
        check_equal("status", rd, 32'h1);
        check_readback(len);
        end_test("single packet");

        for (i = 0; i < 20; i++)
        begin
            axil_write(reg_control, 32'h1);
            len = 1 + int'($unsigned($random(seed)) % 320);
            send_packet(len, 1'b1);
            wait_done(rd);
            check_equal("status", rd, 32'h1);
            check_readback(len);
        end
        end_test("packet stream");

        // Only the first 2048 bytes are kept
        axil_write(reg_control, 32'h1);
        send_packet(2100, 1'b0);
        wait_done(rd);
        check_equal("status", rd, 32'h5);
        check_readback(mem_bytes);
        axil_write(reg_control, 32'h1);
        axil_read(reg_status, rd);
        check_equal("status", rd, 32'h2);
        end_test("overflow");

        $display("summary: %0d run, %0d ok, %0d bad, %0d check errors",
                 test_num, test_num - tests_bad, tests_bad, total_errors);
        if (total_errors == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* files.f */
common/capture_pkg.sv
common/pkt_mem_rd_if.sv
packet_capture/capture_data_writer.sv
packet_capture/capture_meta_latch.sv
packet_capture/capture_regs.sv
src/axi4s_packet_capture.sv
verif/tb_packet_capture.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_packet_capture \
    -f files.f -o sim_packet_capture

./obj_dir/sim_packet_capture | tee sim.log

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0
